// ==== mrelbp_ci.f ====
+incdir+rtl
rtl/pixel_pkg.sv
rtl/ci_pkg.sv
rtl/row_window_buffer.sv
rtl/ci_radius_unit.sv
rtl/ci_result_queue.sv
rtl/mrelbp_ci_top.sv
bench/tb_ci_checks.sv
bench/tb_mrelbp_ci.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_mrelbp_ci
SRCS := $(filter-out +incdir+%,$(shell cat mrelbp_ci.f)) rtl/mrelbp_ci_consts.svh

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
$(SIM): mrelbp_ci.f $(SRCS)
	verilator --binary --timing --assert -f mrelbp_ci.f --top-module tb_mrelbp_ci -o Vtb_mrelbp_ci

# the log decides pass or fail
sim.log: $(SIM)
	-$(SIM) > sim.log 2>&1

run: sim.log
	cat sim.log
	grep -q '^RESULT: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_mrelbp_ci.sv ====
`timescale 1ns/100ps
`include "mrelbp_ci_consts.svh"

module tb_mrelbp_ci;
    import pixel_pkg::*;
    import ci_pkg::*;

    localparam int ROWS = `MRELBP_ROWS;
    localparam int COLS = `MRELBP_COLS;
    localparam int DEPTH = `CI_QUEUE_DEPTH;
    localparam int NUM_FRAMES = 2;
    localparam int WAIT_LIMIT = 2000;

    logic       clk = 1'b0;
    logic       rst_n_i;
    logic       pix_valid_i;
    pixel_t     pix_i;
    logic       out_credit_i;
    logic       rec_valid_o;
    ci_record_t rec_o;
    logic       pix_credit_o;
    logic       chk_fail;

    logic [31:0] lcg_state = 32'h39;
    pixel_t      frame_mem [ROWS][COLS];
    ci_record_t  exp_mem [NUM_FRAMES*ROWS*COLS];
    int          exp_wr = 0;
    int          pix_sent = 0;
    int          ret_cnt = 0;
    int          rec_cnt = 0;
    int          granted = 0;
    int          cycle = 0;
    int          src_credits;
    logic        started = 1'b0;

    assign src_credits = DEPTH - pix_sent + ret_cnt;

    always #4 clk = ~clk;

    mrelbp_ci_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pix_valid_i  (pix_valid_i),
        .pix_i        (pix_i),
        .out_credit_i (out_credit_i),
        .rec_valid_o  (rec_valid_o),
        .rec_o        (rec_o),
        .pix_credit_o (pix_credit_o)
    );

    tb_ci_checks u_checks (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .started_i     (started),
        .rec_valid_i   (rec_valid_o),
        .pix_credit_i  (pix_credit_o),
        .rec_cnt_i     (rec_cnt),
        .granted_i     (granted),
        .src_credits_i (src_credits),
        .fail_o        (chk_fail)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // frame 0 has flat, ramp and random bands, frame 1 is random
    function automatic pixel_t pixel_value(input int f, input int y, input int x,
                                           input logic [31:0] r);
        if (f == 0 && y < 10) begin
            return 8'd100;
        end else if (f == 0 && y < 20) begin
            return pixel_t'(y * 7 + x);
        end
        return r[23:16];
    endfunction

    // center at least the column mean, i.e. (2R+1)*center >= column sum
    function automatic ci_record_t expected_record(input int y, input int x, input bit last);
        logic [2:0] v;
        logic [2:0] ci;
        int         r;
        int         sum;
        for (int i = 0; i < 3; i++) begin
            r = 2 * (i + 1);
            v[i] = (y >= 2 * r);
            ci[i] = 1'b0;
            if (v[i]) begin
                sum = 0;
                for (int k = y - 2 * r; k <= y; k++) begin
                    sum = sum + int'(frame_mem[k][x]);
                end
                ci[i] = ((2 * r + 1) * int'(frame_mem[y - r][x]) >= sum);
            end
        end
        return {last, v, ci};
    endfunction

    // consumer withholds slots for long stretches, never more than DEPTH outstanding
    task automatic grant_step();
        lcg_state = lcg_next(lcg_state);
        out_credit_i = (cycle % 160 >= 60) && lcg_state[29] && (granted - rec_cnt < DEPTH);
        cycle++;
    endtask

    task automatic send_pixel(input int f, input int y, input int x);
        int waited;
        bit sent;
        waited = 0;
        sent = 1'b0;
        while (!sent) begin
            @(posedge clk);
            #1;
            grant_step();
            lcg_state = lcg_next(lcg_state);
            if (src_credits > 0 && lcg_state[31:30] != 2'b00) begin
                started = 1'b1;
                pix_valid_i = 1'b1;
                pix_i = pixel_value(f, y, x, lcg_state);
                frame_mem[y][x] = pix_i;
                pix_sent++;
                if (y >= 4) begin
                    exp_mem[exp_wr] = expected_record(y, x, (y == ROWS - 1) && (x == COLS - 1));
                    exp_wr++;
                end
                sent = 1'b1;
            end else begin
                pix_valid_i = 1'b0;
                waited++;
                assert (waited < WAIT_LIMIT)
                    else fail_run("timeout waiting for a pixel credit");
            end
        end
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (rec_cnt != exp_wr || src_credits != DEPTH) begin
            @(posedge clk);
            #1;
            pix_valid_i = 1'b0;
            grant_step();
            waited++;
            assert (waited < WAIT_LIMIT)
                else fail_run("timeout waiting for the result queue to drain");
        end
    endtask

    always @(posedge chk_fail) begin
        fail_run("a concurrent check in tb_ci_checks failed");
    end

    // outputs sampled mid-cycle, where they are settled
    always @(negedge clk) begin
        if (out_credit_i) granted++;
        if (pix_credit_o) ret_cnt++;
        if (rec_valid_o) begin
            assert (rec_cnt < exp_wr)
                else fail_run("a record left the DUT with none outstanding");
            assert (rec_o == exp_mem[rec_cnt])
                else fail_run($sformatf("Error: rec_o expected 0x%02h got 0x%02h (record %0d)",
                                        exp_mem[rec_cnt], rec_o, rec_cnt));
            rec_cnt++;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        pix_valid_i = 1'b0;
        pix_i = '0;
        out_credit_i = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        // quiet stretch before the first stimulus
        repeat (6) @(posedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int y = 0; y < ROWS; y++) begin
                for (int x = 0; x < COLS; x++) begin
                    send_pixel(f, y, x);
                end
            end
        end
        drain_queue();
        // idle with grants open, any stray record is caught by the monitor
        repeat (40) begin
            @(posedge clk);
            #1;
            grant_step();
        end
        assert (ret_cnt == pix_sent)
            else fail_run($sformatf("Error: pix_credit_o pulses 0x%0h, pixels sent 0x%0h",
                                    ret_cnt, pix_sent));
        if (!chk_fail && rec_cnt == exp_wr) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("record count or concurrent checks disagree at the end of the run");
        end
    end

endmodule

// ==== bench/tb_ci_checks.sv ====
`timescale 1ns/100ps
`include "mrelbp_ci_consts.svh"

module tb_ci_checks (
    input  logic clk,
    input  logic rst_n_i,
    input  logic started_i,
    input  logic rec_valid_i,
    input  logic pix_credit_i,
    input  int   rec_cnt_i,
    input  int   granted_i,
    input  int   src_credits_i,
    output logic fail_o
);
    localparam int DEPTH = `CI_QUEUE_DEPTH;

    logic quiet_err  = 1'b0;
    logic grant_err  = 1'b0;
    logic credit_err = 1'b0;

    assign fail_o = quiet_err | grant_err | credit_err;

    // nothing comes out before the first pixel or grant
    a_quiet_at_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        !started_i |-> (!rec_valid_i && !pix_credit_i))
        else begin
            $display("DUT output went active before any stimulus was applied");
            quiet_err = 1'b1;
        end

    // every record needs a slot granted earlier
    a_recs_within_grants: assert property (@(posedge clk) disable iff (!rst_n_i)
        rec_cnt_i <= granted_i)
        else begin
            $display("Error: rec_valid_o count 0x%0h exceeds out_credit_i count 0x%0h",
                     rec_cnt_i, granted_i);
            grant_err = 1'b1;
        end

    // source credits stay between zero and the queue depth
    a_src_credit_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        (src_credits_i >= 0) && (src_credits_i <= DEPTH))
        else begin
            $display("Error: src_credits 0x%0h outside 0x0 to 0x%0h",
                     src_credits_i, DEPTH);
            credit_err = 1'b1;
        end

endmodule

// ==== rtl/mrelbp_ci_top.sv ====
`timescale 1ns/100ps
`include "mrelbp_ci_consts.svh"

module mrelbp_ci_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               pix_valid_i,
    input  pixel_pkg::pixel_t  pix_i,
    input  logic               out_credit_i,
    output logic               rec_valid_o,
    output ci_pkg::ci_record_t rec_o,
    output logic               pix_credit_o
);
    import pixel_pkg::*;

    localparam int NUM_TAPS = 2 * `MRELBP_MAX_RADIUS + 1;

    pixel_t     tap [NUM_TAPS];
    logic [2:0] win_valid;
    logic [2:0] ci_bit;
    logic [2:0] ci_valid;
    logic [2:0] frame_last_d;
    logic       frame_last;
    logic [1:0] taken_q;

    // accepted-pixel strobe aligned with the radius unit outputs
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            taken_q <= '0;
        end else begin
            taken_q <= {taken_q[0], pix_valid_i};
        end
    end

    row_window_buffer u_buffer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pix_valid_i    (pix_valid_i),
        .pix_i          (pix_i),
        .tap0_o         (tap[0]),
        .tap1_o         (tap[1]),
        .tap2_o         (tap[2]),
        .tap3_o         (tap[3]),
        .tap4_o         (tap[4]),
        .tap5_o         (tap[5]),
        .tap6_o         (tap[6]),
        .tap7_o         (tap[7]),
        .tap8_o         (tap[8]),
        .tap9_o         (tap[9]),
        .tap10_o        (tap[10]),
        .tap11_o        (tap[11]),
        .tap12_o        (tap[12]),
        .win_valid_r2_o (win_valid[0]),
        .win_valid_r4_o (win_valid[1]),
        .win_valid_r6_o (win_valid[2]),
        .frame_last_o   (frame_last)
    );

    // radius 2, 4 and 6
    for (genvar g = 0; g < 3; g++) begin : g_radius
        ci_radius_unit #(
            .RADIUS (2 * (g + 1))
        ) u_ci (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .win_valid_i  (win_valid[g]),
            .frame_last_i (frame_last),
            .tap0_i       (tap[0]),
            .tap1_i       (tap[1]),
            .tap2_i       (tap[2]),
            .tap3_i       (tap[3]),
            .tap4_i       (tap[4]),
            .tap5_i       (tap[5]),
            .tap6_i       (tap[6]),
            .tap7_i       (tap[7]),
            .tap8_i       (tap[8]),
            .tap9_i       (tap[9]),
            .tap10_i      (tap[10]),
            .tap11_i      (tap[11]),
            .tap12_i      (tap[12]),
            .ci_o         (ci_bit[g]),
            .ci_valid_o   (ci_valid[g]),
            .frame_last_o (frame_last_d[g])
        );
    end

    ci_result_queue u_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ci2_i        (ci_bit[0]),
        .ci4_i        (ci_bit[1]),
        .ci6_i        (ci_bit[2]),
        .v2_i         (ci_valid[0]),
        .v4_i         (ci_valid[1]),
        .v6_i         (ci_valid[2]),
        .frame_last_i (frame_last_d[0]),
        .pix_taken_i  (taken_q[1]),
        .out_credit_i (out_credit_i),
        .rec_valid_o  (rec_valid_o),
        .rec_o        (rec_o),
        .pix_credit_o (pix_credit_o)
    );

endmodule

// ==== rtl/ci_result_queue.sv ====
`timescale 1ns/100ps
`include "mrelbp_ci_consts.svh"

module ci_result_queue (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               ci2_i,
    input  logic               ci4_i,
    input  logic               ci6_i,
    input  logic               v2_i,
    input  logic               v4_i,
    input  logic               v6_i,
    input  logic               frame_last_i,
    input  logic               pix_taken_i,
    input  logic               out_credit_i,
    output logic               rec_valid_o,
    output ci_pkg::ci_record_t rec_o,
    output logic               pix_credit_o
);
    import ci_pkg::*;

    localparam int DEPTH = `CI_QUEUE_DEPTH;
    localparam credit_t CREDIT_MAX = '1;

    ci_record_t   fifo_mem [DEPTH];
    ci_record_t   rec_in;
    q_ptr_t       wr_ptr_q;
    q_ptr_t       rd_ptr_q;
    queue_state_e state_q;
    queue_state_e state_d;
    credit_t      out_cred_q;
    credit_t      ret_pend_q;
    credit_t      ret_avail;
    logic         push;
    logic         pop;
    logic         free_ret;

    assign rec_in = {frame_last_i, v6_i, v4_i, v2_i, ci6_i, ci4_i, ci2_i};

    // rows below 4 give no record, their credit goes straight back
    assign push     = pix_taken_i && v2_i;
    assign free_ret = pix_taken_i && !v2_i;
    assign pop      = (state_q != EMPTY) && (out_cred_q != '0);

    assign rec_valid_o = pop;
    assign rec_o       = fifo_mem[rd_ptr_q];

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            EMPTY: begin
                if (push) state_d = PARTIAL;
            end
            PARTIAL: begin
                if (push && !pop && (q_ptr_t'(wr_ptr_q + 1'b1) == rd_ptr_q)) begin
                    state_d = FULL;
                end else if (pop && !push && (q_ptr_t'(rd_ptr_q + 1'b1) == wr_ptr_q)) begin
                    state_d = EMPTY;
                end
            end
            FULL: begin
                if (pop && !push) state_d = PARTIAL;
            end
            default: state_d = EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= EMPTY;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            state_q <= state_d;
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) fifo_mem[wr_ptr_q] <= rec_in;
    end

    // a free return and a pop can land together, so one of them waits
    assign ret_avail    = ret_pend_q + credit_t'(free_ret) + credit_t'(pop);
    assign pix_credit_o = (ret_avail != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_cred_q <= '0;
            ret_pend_q <= '0;
        end else begin
            out_cred_q <= out_cred_q + credit_t'(out_credit_i) - credit_t'(pop);
            ret_pend_q <= ret_avail - credit_t'(pix_credit_o);
        end
    end

    // input credits bound the records in flight to the queue depth
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        push |-> (state_q != FULL))
        else $error("record written into a full queue");

    a_out_cred_no_wrap: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_credit_i && (out_cred_q == CREDIT_MAX)) |-> pop)
        else $error("output credit counter overflow");

    a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        rec_valid_o |-> (out_cred_q != '0))
        else $error("record sent without an output credit");

endmodule

// ==== rtl/ci_radius_unit.sv ====
`timescale 1ns/100ps
`include "mrelbp_ci_consts.svh"

module ci_radius_unit #(
    parameter int RADIUS = 2
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              win_valid_i,
    input  logic              frame_last_i,
    input  pixel_pkg::pixel_t tap0_i,
    input  pixel_pkg::pixel_t tap1_i,
    input  pixel_pkg::pixel_t tap2_i,
    input  pixel_pkg::pixel_t tap3_i,
    input  pixel_pkg::pixel_t tap4_i,
    input  pixel_pkg::pixel_t tap5_i,
    input  pixel_pkg::pixel_t tap6_i,
    input  pixel_pkg::pixel_t tap7_i,
    input  pixel_pkg::pixel_t tap8_i,
    input  pixel_pkg::pixel_t tap9_i,
    input  pixel_pkg::pixel_t tap10_i,
    input  pixel_pkg::pixel_t tap11_i,
    input  pixel_pkg::pixel_t tap12_i,
    output logic              ci_o,
    output logic              ci_valid_o,
    output logic              frame_last_o
);
    import pixel_pkg::*;
    import ci_pkg::*;

    localparam int NEWEST = 2 * `MRELBP_MAX_RADIUS;
    localparam int WIN_LEN = 2 * RADIUS + 1;
    localparam int OLDEST = NEWEST - 2 * RADIUS;

    pixel_t   taps [NEWEST+1];
    col_sum_t col_sum;
    col_sum_t center_scaled;

    assign taps = '{tap0_i, tap1_i, tap2_i, tap3_i, tap4_i, tap5_i, tap6_i,
                    tap7_i, tap8_i, tap9_i, tap10_i, tap11_i, tap12_i};

    // only the 2R+1 newest rows take part
    always_comb begin
        col_sum = '0;
        for (int k = OLDEST; k <= NEWEST; k++) begin
            col_sum = col_sum + col_sum_t'(taps[k]);
        end
    end

    // center >= mean, compared without a divider
    assign center_scaled = col_sum_t'(WIN_LEN) * col_sum_t'(taps[NEWEST-RADIUS]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ci_o         <= 1'b0;
            ci_valid_o   <= 1'b0;
            frame_last_o <= 1'b0;
        end else begin
            ci_o         <= win_valid_i && (center_scaled >= col_sum);
            ci_valid_o   <= win_valid_i;
            frame_last_o <= frame_last_i;
        end
    end

    initial begin
        a_radius_legal: assert (RADIUS == 2 || RADIUS == 4 || RADIUS == 6)
            else $error("unsupported radius %0d", RADIUS);
    end

endmodule

// ==== rtl/row_window_buffer.sv ====
`timescale 1ns/100ps
`include "mrelbp_ci_consts.svh"

module row_window_buffer (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              pix_valid_i,
    input  pixel_pkg::pixel_t pix_i,
    output pixel_pkg::pixel_t tap0_o,
    output pixel_pkg::pixel_t tap1_o,
    output pixel_pkg::pixel_t tap2_o,
    output pixel_pkg::pixel_t tap3_o,
    output pixel_pkg::pixel_t tap4_o,
    output pixel_pkg::pixel_t tap5_o,
    output pixel_pkg::pixel_t tap6_o,
    output pixel_pkg::pixel_t tap7_o,
    output pixel_pkg::pixel_t tap8_o,
    output pixel_pkg::pixel_t tap9_o,
    output pixel_pkg::pixel_t tap10_o,
    output pixel_pkg::pixel_t tap11_o,
    output pixel_pkg::pixel_t tap12_o,
    output logic              win_valid_r2_o,
    output logic              win_valid_r4_o,
    output logic              win_valid_r6_o,
    output logic              frame_last_o
);
    import pixel_pkg::*;

    localparam int NUM_ROWS = 2 * `MRELBP_MAX_RADIUS;
    localparam int COLS = `MRELBP_COLS;
    localparam col_idx_t LAST_COL = col_idx_t'(`MRELBP_COLS - 1);
    localparam row_idx_t LAST_ROW = row_idx_t'(`MRELBP_ROWS - 1);
    // first row where a full window of 2R+1 rows exists
    localparam row_idx_t FIRST_ROW_R2 = row_idx_t'(4);
    localparam row_idx_t FIRST_ROW_R4 = row_idx_t'(8);
    localparam row_idx_t FIRST_ROW_R6 = row_idx_t'(NUM_ROWS);

    pixel_t   line_mem [NUM_ROWS][COLS];
    pixel_t   tap_q [NUM_ROWS+1];
    col_idx_t col_q;
    row_idx_t row_q;
    logic     col_wrap;
    logic     row_wrap;

    assign col_wrap = (col_q == LAST_COL);
    assign row_wrap = (row_q == LAST_ROW);

    // raster position of the pixel being accepted
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pix_valid_i) begin
            if (col_wrap) begin
                col_q <= '0;
                row_q <= row_wrap ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            win_valid_r2_o <= 1'b0;
            win_valid_r4_o <= 1'b0;
            win_valid_r6_o <= 1'b0;
            frame_last_o   <= 1'b0;
        end else begin
            win_valid_r2_o <= pix_valid_i && (row_q >= FIRST_ROW_R2);
            win_valid_r4_o <= pix_valid_i && (row_q >= FIRST_ROW_R4);
            win_valid_r6_o <= pix_valid_i && (row_q >= FIRST_ROW_R6);
            frame_last_o   <= pix_valid_i && col_wrap && row_wrap;
        end
    end

    // each column address shifts up one row, newest row on top
    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            for (int k = 0; k < NUM_ROWS - 1; k++) begin
                line_mem[k][col_q] <= line_mem[k+1][col_q];
                tap_q[k]           <= line_mem[k][col_q];
            end
            line_mem[NUM_ROWS-1][col_q] <= pix_i;
            tap_q[NUM_ROWS-1]           <= line_mem[NUM_ROWS-1][col_q];
            tap_q[NUM_ROWS]             <= pix_i;
        end
    end

    // tap0 is the oldest row
    assign tap0_o  = tap_q[0];
    assign tap1_o  = tap_q[1];
    assign tap2_o  = tap_q[2];
    assign tap3_o  = tap_q[3];
    assign tap4_o  = tap_q[4];
    assign tap5_o  = tap_q[5];
    assign tap6_o  = tap_q[6];
    assign tap7_o  = tap_q[7];
    assign tap8_o  = tap_q[8];
    assign tap9_o  = tap_q[9];
    assign tap10_o = tap_q[10];
    assign tap11_o = tap_q[11];
    assign tap12_o = tap_q[12];

    a_pos_in_frame: assert property (@(posedge clk) disable iff (!rst_n_i)
        (col_q <= LAST_COL) && (row_q <= LAST_ROW))
        else $error("raster counters left the frame: col %0d row %0d", col_q, row_q);

endmodule

// ==== rtl/ci_pkg.sv ====
`include "mrelbp_ci_consts.svh"

package ci_pkg;

    // wide enough for 13 * 255 and the scaled center
    typedef logic [11:0] col_sum_t;

    // {frame_end, v6, v4, v2, ci6, ci4, ci2}
    typedef logic [6:0] ci_record_t;

    // queue slot pointer and credit counters
    typedef logic [$clog2(`CI_QUEUE_DEPTH)-1:0] q_ptr_t;
    typedef logic [`CI_CREDIT_W-1:0] credit_t;

    // fill state of the result FIFO
    typedef enum logic [1:0] {
        EMPTY,
        PARTIAL,
        FULL
    } queue_state_e;

endpackage

// ==== rtl/pixel_pkg.sv ====
package pixel_pkg;

    // one median-filtered pixel
    typedef logic [7:0] pixel_t;

    // raster position inside a frame
    typedef logic [4:0] col_idx_t;
    typedef logic [4:0] row_idx_t;

endpackage

// ==== rtl/mrelbp_ci_consts.svh ====
`ifndef MRELBP_CI_CONSTS_SVH
`define MRELBP_CI_CONSTS_SVH

// frame size in pixels
`define MRELBP_ROWS 30
`define MRELBP_COLS 30

// largest radius, sets the number of buffered rows (2 * radius)
`define MRELBP_MAX_RADIUS 6

// result queue slots, also the credits a source starts with
`define CI_QUEUE_DEPTH 8

// width of the credit counters
`define CI_CREDIT_W 4

`endif
